//--- copper_top.f
+incdir+include
hw/copper_pkg.sv
hw/copper_list_ram.sv
hw/copper_regs.sv
hw/copper_sequencer.sv
hw/copper_coord_xform.sv
hw/copper_top.sv
verification/copper_tb.sv

//--- Bender.yml
package:
  name: copper_top

sources:
  - include_dirs:
      - include
    files:
      - hw/copper_pkg.sv
      - hw/copper_list_ram.sv
      - hw/copper_regs.sv
      - hw/copper_sequencer.sv
      - hw/copper_coord_xform.sv
      - hw/copper_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/copper_tb.sv

//--- verification/copper_tb.sv
// Video frame shrunk to 64x16 counts; list tests park the sequencer on V_tick before loading

`default_nettype none

`include "copper_config.svh"

module copper_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import copper_pkg::*;

	localparam int FRAME_W = 64;
	localparam int FRAME_H = 16;
	localparam int FRAME_CYCLES = FRAME_W * FRAME_H;
	// Reset and register tests plus at most seven frames of waits in the list tests
	localparam int TEST_CYCLES = 8 + 300 + 7 * FRAME_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
	// Wait V on a line the shrunk frame never reaches, so the list holds until V_tick
	localparam gfx_data_t LIST_STOP = 16'h23ff;

	logic CLK;
	logic RSTb;
	gfx_addr_t ADDRESS;
	gfx_data_t DATA_IN;
	logic WR;
	logic V_tick;
	logic H_tick;
	coord_t display_x;
	coord_t display_y;
	gfx_addr_t COPPER_ADDRESS;
	logic COPPER_WR;
	gfx_data_t COPPER_DATA_OUT;
	color_t background_color;
	coord_t display_x_out;
	coord_t display_y_out;

	int cycle_count;
	coord_t model_pan;
	coord_t model_flip;
	logic model_flip_en;

	copper_top u_dut (
		.CLK             (CLK),
		.RSTb            (RSTb),
		.ADDRESS         (ADDRESS),
		.DATA_IN         (DATA_IN),
		.WR              (WR),
		.V_tick          (V_tick),
		.H_tick          (H_tick),
		.display_x       (display_x),
		.display_y       (display_y),
		.COPPER_ADDRESS  (COPPER_ADDRESS),
		.COPPER_WR       (COPPER_WR),
		.COPPER_DATA_OUT (COPPER_DATA_OUT),
		.background_color(background_color),
		.display_x_out   (display_x_out),
		.display_y_out   (display_y_out)
	);

	always #20 CLK = ~CLK;

	// Stand-in for the video timing generator with V_tick at x=0 y=0
	always @(posedge CLK) begin
		if (display_x == coord_t'(FRAME_W - 1)) begin
			display_x <= '0;
			display_y <= (display_y == coord_t'(FRAME_H - 1)) ? '0 : display_y + 1'b1;
		end else begin
			display_x <= display_x + 1'b1;
		end
		V_tick <= (display_x == coord_t'(FRAME_W - 1)) && (display_y == coord_t'(FRAME_H - 1));
		H_tick <= (display_x == coord_t'(FRAME_W - 1));
	end

	always @(posedge CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "run stopped by timeout");
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch");
		end
	endtask

	// All tasks start and end just after a rising edge
	task automatic host_write(input gfx_addr_t addr, input gfx_data_t data);
		ADDRESS <= addr;
		DATA_IN <= data;
		WR <= 1'b1;
		@(posedge CLK);
		WR <= 1'b0;
	endtask

	task automatic write_list_word(input int index, input gfx_data_t word);
		host_write(gfx_addr_t'(`COPPER_LIST_BASE + index), word);
	endtask

	task automatic wait_frame_start();
		do begin
			@(posedge CLK);
		end while (V_tick !== 1'b1);
	endtask

	// Disable, then let V_tick send the sequencer to begin where it idles
	task automatic park_sequencer();
		host_write(`COPPER_REG_CTRL, 16'h0000);
		wait_frame_start();
	endtask

	function automatic coord_t mirror_y(input coord_t y, input coord_t line, input logic en);
		if (en && (y >= line)) begin
			return coord_t'(2 * line - y);
		end
		return y;
	endfunction

	// Outputs at each edge must match the inputs of the edge before
	task automatic follow_coords(input int cycles);
		coord_t prev_x;
		coord_t prev_y;
		@(posedge CLK);
		prev_x = display_x;
		prev_y = display_y;
		repeat (cycles) begin
			@(posedge CLK);
			check_value("display_x_out", display_x_out, coord_t'(prev_x + model_pan));
			check_value("display_y_out", display_y_out,
				mirror_y(prev_y, model_flip, model_flip_en));
			prev_x = display_x;
			prev_y = display_y;
		end
	endtask

	task automatic test_reset_and_regs();
		color_t bg;
		bg = color_t'($urandom);
		check_value("background_color", background_color, `COPPER_BG_RESET);
		check_value("COPPER_WR", COPPER_WR, 1'b0);
		check_value("COPPER_ADDRESS", COPPER_ADDRESS, 12'h000);
		host_write(`COPPER_REG_BG, {4'h0, bg});
		check_value("background_color", background_color, `COPPER_BG_RESET);
		@(posedge CLK);
		check_value("background_color", background_color, bg);
	endtask

	task automatic test_x_pan();
		model_pan = coord_t'($urandom);
		host_write(`COPPER_REG_XPAN, {6'h00, model_pan});
		follow_coords(20);
	endtask

	task automatic test_y_mirror();
		model_flip = coord_t'(2 + ($urandom % 12));
		model_flip_en = 1'b1;
		host_write(`COPPER_REG_YFLIP, {1'b1, 5'h00, model_flip});
		follow_coords(FRAME_CYCLES);
		model_flip_en = 1'b0;
		host_write(`COPPER_REG_YFLIP, {6'h00, model_flip});
		follow_coords(2 * FRAME_W);
	endtask

	task automatic test_copper_reg_write();
		gfx_addr_t addr;
		gfx_data_t data;
		gfx_addr_t seen_addr;
		gfx_data_t seen_data;
		int pulses;
		addr = gfx_addr_t'($urandom);
		data = gfx_data_t'($urandom);
		seen_addr = '0;
		seen_data = '0;
		pulses = 0;
		park_sequencer();
		write_list_word(0, {4'd9, addr});
		write_list_word(1, data);
		write_list_word(2, LIST_STOP);
		host_write(`COPPER_REG_CTRL, 16'h0001);
		wait_frame_start();
		// Count strobes over one whole frame
		do begin
			@(posedge CLK);
			if (COPPER_WR === 1'b1) begin
				pulses = pulses + 1;
				seen_addr = COPPER_ADDRESS;
				seen_data = COPPER_DATA_OUT;
			end
		end while (V_tick !== 1'b1);
		check_value("COPPER_WR pulses", pulses, 1);
		check_value("COPPER_ADDRESS", seen_addr, addr);
		check_value("COPPER_DATA_OUT", seen_data, data);
	endtask

	task automatic test_wait_line();
		coord_t line;
		color_t old_bg;
		color_t new_bg;
		int settle;
		line = coord_t'(4 + ($urandom % 9));
		old_bg = color_t'($urandom);
		new_bg = old_bg ^ color_t'(1 + ($urandom % 4095));
		settle = 0;
		park_sequencer();
		write_list_word(0, {4'd2, 2'b00, line});
		write_list_word(1, {4'd12, new_bg});
		write_list_word(2, LIST_STOP);
		host_write(`COPPER_REG_BG, {4'h0, old_bg});
		host_write(`COPPER_REG_CTRL, 16'h0001);
		do begin
			@(posedge CLK);
			if (display_y < line) begin
				check_value("background_color", background_color, old_bg);
			end
		end while (display_y < line);
		while ((background_color !== new_bg) && (settle < 8)) begin
			@(posedge CLK);
			settle = settle + 1;
		end
		check_value("background_color", background_color, new_bg);
	endtask

	task automatic test_skip_and_jump();
		color_t skipped_bg;
		color_t entry_bg;
		coord_t unreached_pan;
		skipped_bg = color_t'($urandom);
		entry_bg = skipped_bg ^ color_t'(1 + ($urandom % 4095));
		unreached_pan = model_pan ^ coord_t'(1 + ($urandom % 1023));
		park_sequencer();
		// Word 0 runs once, then the skip on any line and the jump back loop forever
		write_list_word(0, {4'd12, entry_bg});
		write_list_word(1, 16'h4000);
		write_list_word(2, {4'd12, skipped_bg});
		write_list_word(3, 16'h1001);
		write_list_word(4, {4'd10, 2'b00, unreached_pan});
		host_write(`COPPER_REG_BG, {4'h0, skipped_bg});
		host_write(`COPPER_REG_CTRL, 16'h0001);
		repeat (40) @(posedge CLK);
		check_value("background_color", background_color, entry_bg);
		follow_coords(4);
	endtask

	initial begin
		CLK = 1'b0;
		RSTb = 1'b0;
		ADDRESS = '0;
		DATA_IN = '0;
		WR = 1'b0;
		V_tick = 1'b0;
		H_tick = 1'b0;
		display_x = '0;
		display_y = '0;
		cycle_count = 0;
		model_pan = '0;
		model_flip = '0;
		model_flip_en = 1'b0;
		void'($urandom(32'h89c));

		repeat (8) @(posedge CLK);
		RSTb <= 1'b1;
		@(posedge CLK);

		test_reset_and_regs();
		test_x_pan();
		test_y_mirror();
		test_copper_reg_write();
		test_wait_line();
		test_skip_and_jump();

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/copper_top.sv
// H_tick is accepted but unused, line timing comes from display_x; parent core muxes COPPER_WR

`default_nettype none

module copper_top (
	input wire logic CLK,
	input wire logic RSTb,

	// Host register bus
	input wire copper_pkg::gfx_addr_t ADDRESS,
	input wire copper_pkg::gfx_data_t DATA_IN,
	input wire logic WR,

	// Video timing
	input wire logic V_tick,
	input wire logic H_tick,
	input wire copper_pkg::coord_t display_x,
	input wire copper_pkg::coord_t display_y,

	// Copper writes towards the graphics registers
	output copper_pkg::gfx_addr_t COPPER_ADDRESS,
	output logic COPPER_WR,
	output copper_pkg::gfx_data_t COPPER_DATA_OUT,

	output copper_pkg::color_t background_color,

	// Panned and mirrored coordinates for the layers
	output copper_pkg::coord_t display_x_out,
	output copper_pkg::coord_t display_y_out
);

	import copper_pkg::*;

	list_addr_t list_addr;
	gfx_data_t list_data;
	coord_t x_pan;
	coord_t y_flip;
	logic y_flip_en;

	copper_ctl_if ctl_bus ();

	copper_list_ram u_list_ram (
		.CLK     (CLK),
		.rd_addr (list_addr),
		.rd_data (list_data),
		.ADDRESS (ADDRESS),
		.DATA_IN (DATA_IN),
		.WR      (WR)
	);

	copper_regs u_regs (
		.CLK              (CLK),
		.RSTb             (RSTb),
		.ADDRESS          (ADDRESS),
		.DATA_IN          (DATA_IN),
		.WR               (WR),
		.ctl              (ctl_bus.regs),
		.background_color (background_color),
		.x_pan            (x_pan),
		.y_flip           (y_flip),
		.y_flip_en        (y_flip_en)
	);

	copper_sequencer u_sequencer (
		.CLK             (CLK),
		.RSTb            (RSTb),
		.V_tick          (V_tick),
		.display_x       (display_x),
		.display_y       (display_y),
		.list_addr       (list_addr),
		.list_data       (list_data),
		.ctl             (ctl_bus.seq),
		.COPPER_ADDRESS  (COPPER_ADDRESS),
		.COPPER_WR       (COPPER_WR),
		.COPPER_DATA_OUT (COPPER_DATA_OUT)
	);

	copper_coord_xform u_coord_xform (
		.CLK           (CLK),
		.display_x     (display_x),
		.display_y     (display_y),
		.x_pan         (x_pan),
		.y_flip        (y_flip),
		.y_flip_en     (y_flip_en),
		.display_x_out (display_x_out),
		.display_y_out (display_y_out)
	);

endmodule

`default_nettype wire

//--- hw/copper_coord_xform.sv
// Outputs lag inputs by one cycle; all arithmetic wraps at 1024 and there is no reset

`default_nettype none

module copper_coord_xform (
	input wire logic CLK,
	input wire copper_pkg::coord_t display_x,
	input wire copper_pkg::coord_t display_y,
	input wire copper_pkg::coord_t x_pan,
	input wire copper_pkg::coord_t y_flip,
	input wire logic y_flip_en,
	output copper_pkg::coord_t display_x_out,
	output copper_pkg::coord_t display_y_out
);

	import copper_pkg::*;

	coord_t x_next;
	coord_t y_next;
	coord_t y_mirrored;

	assign x_next = display_x + x_pan;

	// Reflect about the mirror line, lines above it pass unchanged
	assign y_mirrored = y_flip + y_flip - display_y;

	always_comb begin
		if (y_flip_en && (display_y >= y_flip)) begin
			y_next = y_mirrored;
		end else begin
			y_next = display_y;
		end
	end

	always_ff @(posedge CLK) begin
		display_x_out <= x_next;
		display_y_out <= y_next;
	end

endmodule

`default_nettype wire

//--- hw/copper_sequencer.sv
// Jump targets are truncated to the list address width; waits compare with >= and never time out

`default_nettype none

module copper_sequencer (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic V_tick,
	input wire copper_pkg::coord_t display_x,
	input wire copper_pkg::coord_t display_y,
	output copper_pkg::list_addr_t list_addr,
	input wire copper_pkg::gfx_data_t list_data,
	copper_ctl_if.seq ctl,
	output copper_pkg::gfx_addr_t COPPER_ADDRESS,
	output logic COPPER_WR,
	output copper_pkg::gfx_data_t COPPER_DATA_OUT
);

	import copper_pkg::*;

	copper_state_t state;
	copper_state_t state_next;
	list_addr_t pc;
	list_addr_t pc_next;
	list_addr_t pc_inc;
	coord_t wait_tgt;
	coord_t wait_tgt_next;
	gfx_addr_t cp_addr_next;
	gfx_data_t cp_data_next;
	logic cp_wr_next;
	copper_op_t op;
	coord_t operand;
	logic bg_wr;
	logic xpan_wr;

	// RAM returns the word at pc one cycle later, so execute sees word pc-1
	assign list_addr = pc;
	assign pc_inc = pc + 1'b1;
	assign op = copper_op_t'(list_data[15:12]);
	assign operand = coord_t'(list_data[9:0]);

	assign ctl.bg_wr = bg_wr;
	assign ctl.xpan_wr = xpan_wr;
	assign ctl.op_data = list_data;

	always_comb begin
		state_next = state;
		pc_next = pc;
		wait_tgt_next = wait_tgt;
		cp_addr_next = COPPER_ADDRESS;
		cp_data_next = COPPER_DATA_OUT;
		cp_wr_next = 1'b0;
		bg_wr = 1'b0;
		xpan_wr = 1'b0;

		// Frame restart beats everything
		if (V_tick) begin
			state_next = ST_BEGIN;
			pc_next = '0;
		end else begin
			case (state)
				ST_BEGIN: begin
					if (ctl.enable) begin
						state_next = ST_EXECUTE;
						pc_next = pc_inc;
					end
				end
				ST_EXECUTE: begin
					case (op)
						OP_JUMP: begin
							// Upper target bits beyond the list size are dropped
							pc_next = list_addr_t'(list_data[11:0]);
							state_next = ST_BEGIN;
						end
						OP_WAIT_V: begin
							state_next = ST_WAIT_V;
							wait_tgt_next = operand;
						end
						OP_WAIT_H: begin
							state_next = ST_WAIT_H;
							wait_tgt_next = operand;
						end
						OP_SKIP_V: begin
							// Resync through begin drops the prefetched word
							pc_next = pc_inc;
							if (display_y >= operand) begin
								state_next = ST_BEGIN;
							end
						end
						OP_SKIP_H: begin
							pc_next = pc_inc;
							if (display_x >= operand) begin
								state_next = ST_BEGIN;
							end
						end
						OP_BG_WAIT_LINE: begin
							bg_wr = 1'b1;
							state_next = ST_WAIT_V;
							wait_tgt_next = display_y + 10'd1;
						end
						OP_WAIT_V_REL: begin
							state_next = ST_WAIT_V;
							wait_tgt_next = display_y + operand;
						end
						OP_WAIT_H_REL: begin
							state_next = ST_WAIT_H;
							wait_tgt_next = display_x + operand;
						end
						OP_WRITE_REG: begin
							state_next = ST_WRITE_REG;
							pc_next = pc_inc;
							cp_addr_next = gfx_addr_t'(list_data[11:0]);
						end
						OP_XPAN: begin
							xpan_wr = 1'b1;
							pc_next = pc_inc;
						end
						OP_XPAN_WAIT_LINE: begin
							xpan_wr = 1'b1;
							state_next = ST_WAIT_V;
							wait_tgt_next = display_y + 10'd1;
						end
						OP_BG: begin
							bg_wr = 1'b1;
							pc_next = pc_inc;
						end
						default: begin
							pc_next = pc_inc;
						end
					endcase
				end
				ST_WAIT_V: begin
					if (display_y >= wait_tgt) begin
						state_next = ST_EXECUTE;
						pc_next = pc_inc;
					end
				end
				ST_WAIT_H: begin
					if (display_x >= wait_tgt) begin
						state_next = ST_EXECUTE;
						pc_next = pc_inc;
					end
				end
				ST_WRITE_REG: begin
					// Data word follows the write opcode in the list
					cp_data_next = list_data;
					cp_wr_next = 1'b1;
					pc_next = pc_inc;
					state_next = ST_EXECUTE;
				end
				default: begin
					state_next = ST_BEGIN;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= ST_EXECUTE;
			pc <= '0;
			COPPER_ADDRESS <= '0;
			COPPER_WR <= 1'b0;
		end else begin
			state <= state_next;
			pc <= pc_next;
			COPPER_ADDRESS <= cp_addr_next;
			COPPER_WR <= cp_wr_next;
		end
	end

	always_ff @(posedge CLK) begin
		wait_tgt <= wait_tgt_next;
		COPPER_DATA_OUT <= cp_data_next;
	end

	// Bus write strobe is a single-cycle pulse
	a_wr_one_cycle: assert property (
		@(posedge CLK) disable iff (!RSTb)
		COPPER_WR |=> !COPPER_WR
	);

	a_state_legal: assert property (
		@(posedge CLK) disable iff (!RSTb)
		state inside {ST_BEGIN, ST_EXECUTE, ST_WAIT_V, ST_WAIT_H, ST_WRITE_REG}
	);

endmodule

`default_nettype wire

//--- hw/copper_regs.sv
// Host and copper may write the same register in one cycle; the copper write wins

`default_nettype none

`include "copper_config.svh"

module copper_regs (
	input wire logic CLK,
	input wire logic RSTb,
	input wire copper_pkg::gfx_addr_t ADDRESS,
	input wire copper_pkg::gfx_data_t DATA_IN,
	input wire logic WR,
	copper_ctl_if.regs ctl,
	output copper_pkg::color_t background_color,
	output copper_pkg::coord_t x_pan,
	output copper_pkg::coord_t y_flip,
	output logic y_flip_en
);

	import copper_pkg::*;

	logic enable_r;

	assign ctl.enable = enable_r;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			enable_r <= 1'b0;
			y_flip <= '0;
			y_flip_en <= 1'b0;
			background_color <= `COPPER_BG_RESET;
			x_pan <= '0;
		end else begin
			// Host side first
			if (WR) begin
				case (ADDRESS)
					`COPPER_REG_CTRL: begin
						enable_r <= DATA_IN[0];
					end
					`COPPER_REG_YFLIP: begin
						// Bit 15 enables the mirror, 9:0 is the mirror line
						y_flip <= coord_t'(DATA_IN[9:0]);
						y_flip_en <= DATA_IN[15];
					end
					`COPPER_REG_BG: begin
						background_color <= color_t'(DATA_IN[11:0]);
					end
					`COPPER_REG_XPAN: begin
						x_pan <= coord_t'(DATA_IN[9:0]);
					end
					default: begin
					end
				endcase
			end

			// Copper strobes override the host
			if (ctl.bg_wr) begin
				background_color <= color_t'(ctl.op_data[11:0]);
			end
			if (ctl.xpan_wr) begin
				x_pan <= coord_t'(ctl.op_data[9:0]);
			end
		end
	end

	// One list word sets either the background or the pan, never both
	a_single_copper_strobe: assert property (
		@(posedge CLK) disable iff (!RSTb)
		!(ctl.bg_wr && ctl.xpan_wr)
	);

endmodule

`default_nettype wire

//--- hw/copper_list_ram.sv
// Host writes land only inside the list window; read data lags rd_addr by one cycle, no reset

`default_nettype none

`include "copper_config.svh"

module copper_list_ram (
	input wire logic CLK,
	input wire copper_pkg::list_addr_t rd_addr,
	output logic [15:0] rd_data,
	input wire copper_pkg::gfx_addr_t ADDRESS,
	input wire copper_pkg::gfx_data_t DATA_IN,
	input wire logic WR
);

	import copper_pkg::*;

	localparam int DEPTH = 2 ** $bits(list_addr_t);

	gfx_data_t mem [0:DEPTH-1];
	list_addr_t wr_addr;
	logic in_window;

	// Window decode, kept here so the register block never sees list addresses
	assign in_window = (ADDRESS >= `COPPER_LIST_BASE) && (ADDRESS <= `COPPER_LIST_LAST);
	assign wr_addr = list_addr_t'(ADDRESS - `COPPER_LIST_BASE);

	always_ff @(posedge CLK) begin
		if (WR && in_window) begin
			mem[wr_addr] <= DATA_IN;
		end
	end

	// Registered read port
	always_ff @(posedge CLK) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- hw/copper_pkg.sv
// Types shared by the copper blocks; list address width follows the config header

`default_nettype none

`include "copper_config.svh"

package copper_pkg;

	typedef logic [11:0] gfx_addr_t;
	typedef logic [15:0] gfx_data_t;
	typedef logic [9:0] coord_t;
	// RGB444
	typedef logic [11:0] color_t;
	typedef logic [`COPPER_LIST_AW-1:0] list_addr_t;

	// Opcode in bits 15:12 of each list word, unlisted codes act as no-op
	typedef enum logic [3:0] {
		OP_JUMP           = 4'd1,
		OP_WAIT_V         = 4'd2,
		OP_WAIT_H         = 4'd3,
		OP_SKIP_V         = 4'd4,
		OP_SKIP_H         = 4'd5,
		OP_BG_WAIT_LINE   = 4'd6,
		OP_WAIT_V_REL     = 4'd7,
		OP_WAIT_H_REL     = 4'd8,
		OP_WRITE_REG      = 4'd9,
		OP_XPAN           = 4'd10,
		OP_XPAN_WAIT_LINE = 4'd11,
		OP_BG             = 4'd12
	} copper_op_t;

	typedef enum logic [2:0] {
		ST_BEGIN     = 3'd0,
		ST_EXECUTE   = 3'd1,
		ST_WAIT_V    = 3'd2,
		ST_WAIT_H    = 3'd3,
		ST_WRITE_REG = 3'd4
	} copper_state_t;

endpackage

// Sequencer to register block control path
interface copper_ctl_if;
	logic enable;
	logic bg_wr;
	logic xpan_wr;
	// Instruction word currently being executed
	copper_pkg::gfx_data_t op_data;

	modport seq(input enable, output bg_wr, output xpan_wr, output op_data);
	modport regs(output enable, input bg_wr, input xpan_wr, input op_data);
endinterface

`default_nettype wire

//--- include/copper_config.svh
// Shared build constants; list window must stay aligned to a power of two of size 2**LIST_AW

`ifndef COPPER_CONFIG_SVH
`define COPPER_CONFIG_SVH

// List RAM address width, 512 instruction words
`define COPPER_LIST_AW 9

// Host control registers on the graphics register bus
`define COPPER_REG_CTRL 12'hd20
`define COPPER_REG_YFLIP 12'hd21
`define COPPER_REG_BG 12'hd22
`define COPPER_REG_XPAN 12'hd23

// Host-writable list window, 12'h400 to 12'h5ff
`define COPPER_LIST_BASE 12'h400
`define COPPER_LIST_LAST 12'h5ff

// Background shown until the host or the list changes it
`define COPPER_BG_RESET 12'hf00

`endif
